//--- filelist.f
logic/apple_video_pkg.sv
logic/pixel_capture.sv
logic/color_expand.sv
logic/video_output.sv
logic/joy_mapper.sv
logic/apple_video_out.sv
sim/tb_apple_video_out.sv

//--- logic/apple_video_out.sv
`timescale 1ns/10ps

module apple_video_out import apple_video_pkg::*; (
	input  logic          CLK_VIDEO,
	input  logic          rst_n,
	// Core video
	input  logic          pixel_rate_normal,
	input  color_level_t  r_level,
	input  color_level_t  g_level,
	input  color_level_t  b_level,
	input  logic          hsync,
	input  logic          vsync,
	input  logic          hblank,
	input  logic          vblank,
	// Menu settings
	input  display_mode_t display_mode,
	input  scale_t        scale,
	input  logic          forced_scandoubler,
	input  logic [1:0]    aspect_mode,
	// Controller inputs
	input  joy_digital_t  joystick,
	input  joy_analog_t   joystick_analog,
	input  axis_t         paddle,
	input  logic          axes_normal,
	input  logic          paddle_x,
	input  logic          paddle_y,
	// Video out
	output logic          ce_pixel,
	output channel_t      vga_r,
	output channel_t      vga_g,
	output channel_t      vga_b,
	output logic          vga_hs,
	output logic          vga_vs,
	output logic          vga_de,
	output scanline_t     vga_sl,
	output logic          hq2x,
	output logic          scandoubler,
	output aspect_t       video_arx,
	output aspect_t       video_ary,
	// Controller out
	output joy_digital_t  joy_digital,
	output joy_analog_t   joy_analog
);

	// ============================================================
	// Stage wiring
	// ============================================================

	logic         ce_pix;
	color_level_t cap_r, cap_g, cap_b;
	logic         cap_hs, cap_vs, cap_blank;
	channel_t     exp_r, exp_g, exp_b;
	logic         exp_hs, exp_vs, exp_blank;

	assign ce_pixel = ce_pix;

	// Divider and input sampling
	pixel_capture u_capture (
		.CLK_VIDEO(CLK_VIDEO), .rst_n(rst_n), .pixel_rate_normal(pixel_rate_normal),
		.r_level(r_level), .g_level(g_level), .b_level(b_level),
		.hsync(hsync), .vsync(vsync), .hblank(hblank), .vblank(vblank),
		.ce_pix(ce_pix), .cap_r(cap_r), .cap_g(cap_g), .cap_b(cap_b),
		.cap_hs(cap_hs), .cap_vs(cap_vs), .cap_blank(cap_blank)
	);

	// Level expansion and display mode
	color_expand u_expand (
		.CLK_VIDEO(CLK_VIDEO), .rst_n(rst_n), .ce_pix(ce_pix),
		.display_mode(display_mode),
		.cap_r(cap_r), .cap_g(cap_g), .cap_b(cap_b),
		.cap_hs(cap_hs), .cap_vs(cap_vs), .cap_blank(cap_blank),
		.exp_r(exp_r), .exp_g(exp_g), .exp_b(exp_b),
		.exp_hs(exp_hs), .exp_vs(exp_vs), .exp_blank(exp_blank)
	);

	// Output timing and scaler decode
	video_output u_output (
		.CLK_VIDEO(CLK_VIDEO), .rst_n(rst_n), .ce_pix(ce_pix),
		.exp_r(exp_r), .exp_g(exp_g), .exp_b(exp_b),
		.exp_hs(exp_hs), .exp_vs(exp_vs), .exp_blank(exp_blank),
		.scale(scale), .forced_scandoubler(forced_scandoubler), .aspect_mode(aspect_mode),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
		.vga_hs(vga_hs), .vga_vs(vga_vs), .vga_de(vga_de),
		.vga_sl(vga_sl), .hq2x(hq2x), .scandoubler(scandoubler),
		.video_arx(video_arx), .video_ary(video_ary)
	);

	// Joystick branch runs beside the video pipeline
	joy_mapper u_joy (
		.CLK_VIDEO(CLK_VIDEO), .rst_n(rst_n),
		.joystick(joystick), .joystick_analog(joystick_analog), .paddle(paddle),
		.axes_normal(axes_normal), .paddle_x(paddle_x), .paddle_y(paddle_y),
		.joy_digital(joy_digital), .joy_analog(joy_analog)
	);

endmodule

//--- logic/apple_video_pkg.sv
// ============================================================
// Shared widths and constants for the video conditioning path
// ============================================================

package apple_video_pkg;

	// Basic field widths
	localparam int LEVEL_W   = 2;
	localparam int CHANNEL_W = 8;
	localparam int AXIS_W    = 8;
	localparam int SCALE_W   = 3;
	localparam int ASPECT_W  = 12;

	// Width of the free running pixel divider
	localparam int CE_DIV_W = 3;

	// ============================================================
	// Video types
	// ============================================================

	// 2-bit colour level straight from the core
	typedef logic [LEVEL_W-1:0] color_level_t;

	// Full 8-bit output channel
	typedef logic [CHANNEL_W-1:0] channel_t;

	// Display menu choice
	typedef enum logic [1:0] {
		DISP_COLOR = 2'd0,
		DISP_BW    = 2'd1,
		DISP_GREEN = 2'd2,
		DISP_AMBER = 2'd3
	} display_mode_t;

	// Scaler menu code and derived scanline level
	typedef logic [SCALE_W-1:0] scale_t;
	typedef logic [1:0]         scanline_t;

	// Aspect ratio field for the scaler
	typedef logic [ASPECT_W-1:0] aspect_t;

	// ============================================================
	// Controller types
	// ============================================================

	// One analog axis or paddle byte
	typedef logic [AXIS_W-1:0] axis_t;

	// X in the high byte, Y in the low byte
	typedef logic [2*AXIS_W-1:0] joy_analog_t;

	// Fire2, fire1, up, down, left, right
	typedef logic [5:0] joy_digital_t;

	// Original 4:3 picture
	localparam aspect_t ASPECT_ORIG_X = 12'd4;
	localparam aspect_t ASPECT_ORIG_Y = 12'd3;

	// Scaler code that picks HQ2x filtering
	localparam scale_t HQ2X_SCALE = 3'd1;

endpackage

//--- logic/color_expand.sv
`timescale 1ns/10ps

module color_expand import apple_video_pkg::*; (
	input  logic          CLK_VIDEO,
	input  logic          rst_n,
	input  logic          ce_pix,
	input  display_mode_t display_mode,
	input  color_level_t  cap_r,
	input  color_level_t  cap_g,
	input  color_level_t  cap_b,
	input  logic          cap_hs,
	input  logic          cap_vs,
	input  logic          cap_blank,
	output channel_t      exp_r,
	output channel_t      exp_g,
	output channel_t      exp_b,
	output logic          exp_hs,
	output logic          exp_vs,
	output logic          exp_blank
);

	// Repeat the two level bits across the byte
	function automatic channel_t expand_level(input color_level_t lvl);
		return {4{lvl}};
	endfunction

	// Brightest of the three levels
	function automatic color_level_t max_level(
		input color_level_t a,
		input color_level_t b,
		input color_level_t c
	);
		color_level_t m;
		m = a;
		if (b > m)
			m = b;
		if (c > m)
			m = c;
		return m;
	endfunction

	// ============================================================
	// Display mode mapping
	// ============================================================

	channel_t lum;
	channel_t next_r, next_g, next_b;

	assign lum = expand_level(max_level(cap_r, cap_g, cap_b));

	always_comb begin
		// Colour by default
		next_r = expand_level(cap_r);
		next_g = expand_level(cap_g);
		next_b = expand_level(cap_b);
		case (display_mode)
			DISP_BW: begin
				next_r = lum;
				next_g = lum;
				next_b = lum;
			end
			DISP_GREEN: begin
				next_r = '0;
				next_g = lum;
				next_b = '0;
			end
			DISP_AMBER: begin
				// Half strength green gives the amber tint
				next_r = lum;
				next_g = lum >> 1;
				next_b = '0;
			end
			default: ;
		endcase
	end

	// Colour and timing move together one pixel later
	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			exp_r     <= '0;
			exp_g     <= '0;
			exp_b     <= '0;
			exp_hs    <= 1'b0;
			exp_vs    <= 1'b0;
			exp_blank <= 1'b0;
		end else if (ce_pix) begin
			exp_r     <= next_r;
			exp_g     <= next_g;
			exp_b     <= next_b;
			exp_hs    <= cap_hs;
			exp_vs    <= cap_vs;
			exp_blank <= cap_blank;
		end
	end

endmodule

//--- logic/joy_mapper.sv
`timescale 1ns/10ps

module joy_mapper import apple_video_pkg::*; (
	input  logic         CLK_VIDEO,
	input  logic         rst_n,
	input  joy_digital_t joystick,
	input  joy_analog_t  joystick_analog,
	input  axis_t        paddle,
	input  logic         axes_normal,
	input  logic         paddle_x,
	input  logic         paddle_y,
	output joy_digital_t joy_digital,
	output joy_analog_t  joy_analog
);

	// ============================================================
	// Analog path
	// ============================================================

	axis_t        pdl;
	joy_analog_t  stick;
	joy_analog_t  next_analog;
	joy_digital_t dir_mask;

	// Unsigned paddle to the signed axis range
	assign pdl = {~paddle[7], paddle[6:0]};

	// Optional X/Y swap
	assign stick = axes_normal ? joystick_analog :
		{joystick_analog[7:0], joystick_analog[15:8]};

	// Paddle can stand in for either axis
	assign next_analog = {
		paddle_x ? pdl : stick[15:8],
		paddle_y ? pdl : stick[7:0]
	};

	// ============================================================
	// Digital masking
	// ============================================================

	// Fire buttons always pass
	// Up/down drop while Y is deflected, left/right while X is
	assign dir_mask = {2'b11, {2{~|stick[7:0]}}, {2{~|stick[15:8]}}};

	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			joy_digital <= '0;
			joy_analog  <= '0;
		end else begin
			joy_digital <= joystick & dir_mask;
			joy_analog  <= next_analog;
		end
	end

endmodule

//--- logic/pixel_capture.sv
`timescale 1ns/10ps

module pixel_capture import apple_video_pkg::*; (
	input  logic         CLK_VIDEO,
	input  logic         rst_n,
	input  logic         pixel_rate_normal,
	input  color_level_t r_level,
	input  color_level_t g_level,
	input  color_level_t b_level,
	input  logic         hsync,
	input  logic         vsync,
	input  logic         hblank,
	input  logic         vblank,
	output logic         ce_pix,
	output color_level_t cap_r,
	output color_level_t cap_g,
	output color_level_t cap_b,
	output logic         cap_hs,
	output logic         cap_vs,
	output logic         cap_blank
);

	// ============================================================
	// Pixel clock enable
	// ============================================================

	// Free running divider
	logic [CE_DIV_W-1:0] div;

	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			div    <= '0;
			ce_pix <= 1'b0;
		end else begin
			div <= div + 1'b1;
			// Normal rate is one clock in 8, double rate one in 4
			if (pixel_rate_normal)
				ce_pix <= &div;
			else
				ce_pix <= &div[1:0];
		end
	end

	// ============================================================
	// Input capture
	// ============================================================

	// Sample the core outputs once per pixel
	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			cap_r     <= '0;
			cap_g     <= '0;
			cap_b     <= '0;
			cap_hs    <= 1'b0;
			cap_vs    <= 1'b0;
			cap_blank <= 1'b0;
		end else if (ce_pix) begin
			cap_r  <= r_level;
			cap_g  <= g_level;
			cap_b  <= b_level;
			cap_hs <= hsync;
			cap_vs <= vsync;
			// Later stages only care about any blanking
			cap_blank <= hblank | vblank;
		end
	end

endmodule

//--- logic/video_output.sv
`timescale 1ns/10ps

module video_output import apple_video_pkg::*; (
	input  logic      CLK_VIDEO,
	input  logic      rst_n,
	input  logic      ce_pix,
	input  channel_t  exp_r,
	input  channel_t  exp_g,
	input  channel_t  exp_b,
	input  logic      exp_hs,
	input  logic      exp_vs,
	input  logic      exp_blank,
	input  scale_t    scale,
	input  logic      forced_scandoubler,
	input  logic [1:0] aspect_mode,
	output channel_t  vga_r,
	output channel_t  vga_g,
	output channel_t  vga_b,
	output logic      vga_hs,
	output logic      vga_vs,
	output logic      vga_de,
	output scanline_t vga_sl,
	output logic      hq2x,
	output logic      scandoubler,
	output aspect_t   video_arx,
	output aspect_t   video_ary
);

	// ============================================================
	// Pixel output register
	// ============================================================

	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
			vga_de <= 1'b0;
		end else if (ce_pix) begin
			vga_hs <= exp_hs;
			vga_vs <= exp_vs;
			vga_de <= ~exp_blank;
			// Black outside the active area
			vga_r <= exp_blank ? '0 : exp_r;
			vga_g <= exp_blank ? '0 : exp_g;
			vga_b <= exp_blank ? '0 : exp_b;
		end
	end

	// ============================================================
	// Scaler and aspect decode
	// ============================================================

	// Scanline level is one below the menu code
	scanline_t  sl_code;
	logic [1:0] ar_code;

	assign sl_code = scale[1:0] - 2'd1;
	assign ar_code = aspect_mode - 2'd1;

	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			vga_sl      <= '0;
			hq2x        <= 1'b0;
			scandoubler <= 1'b0;
			video_arx   <= '0;
			video_ary   <= '0;
		end else begin
			vga_sl      <= (scale != '0) ? sl_code : '0;
			hq2x        <= (scale == HQ2X_SCALE);
			scandoubler <= (scale != '0) | forced_scandoubler;
			// Nonzero modes pass the scaler's full screen and custom codes
			if (aspect_mode == 2'd0) begin
				video_arx <= ASPECT_ORIG_X;
				video_ary <= ASPECT_ORIG_Y;
			end else begin
				video_arx <= aspect_t'(ar_code);
				video_ary <= '0;
			end
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it
# A failing check ends in $fatal, which gives a nonzero exit status
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_apple_video_out \
	-f filelist.f \
	-o tb_apple_video_out

./obj_dir/tb_apple_video_out

//--- sim/tb_apple_video_out.sv
`timescale 1ns/10ps

module tb_apple_video_out import apple_video_pkg::*; ();

	// Limit sits well above the roughly 2650 clock run
	localparam int CYCLE_LIMIT = 4000;

	// DUT ports
	logic          CLK_VIDEO;
	logic          rst_n;
	logic          pixel_rate_normal;
	color_level_t  r_level, g_level, b_level;
	logic          hsync, vsync, hblank, vblank;
	display_mode_t display_mode;
	scale_t        scale;
	logic          forced_scandoubler;
	logic [1:0]    aspect_mode;
	joy_digital_t  joystick;
	joy_analog_t   joystick_analog;
	axis_t         paddle;
	logic          axes_normal, paddle_x, paddle_y;
	logic          ce_pixel;
	channel_t      vga_r, vga_g, vga_b;
	logic          vga_hs, vga_vs, vga_de;
	scanline_t     vga_sl;
	logic          hq2x, scandoubler;
	aspect_t       video_arx, video_ary;
	joy_digital_t  joy_digital;
	joy_analog_t   joy_analog;

	// Reference model state
	int            cycles = 0;
	logic [2:0]    m_div;
	logic          m_ce;
	// Entry is {mode, hs, vs, blank, r, g, b}
	logic [10:0]   pix_q[$];
	logic [10:0]   head;
	channel_t      e_r, e_g, e_b;
	logic          e_hs, e_vs, e_de;
	scanline_t     e_sl;
	logic          e_hq, e_sd;
	aspect_t       e_arx, e_ary;
	joy_analog_t   stk, e_ja;
	joy_digital_t  e_jd;
	int            rate_hold;
	logic          last_rate;
	int            gap;
	logic          seen_ce;

	apple_video_out dut_i (.*);

	initial begin
		CLK_VIDEO = 1'b0;
		forever #20 CLK_VIDEO = ~CLK_VIDEO;
	end

	// ============================================================
	// Failure reporting
	// ============================================================

	task automatic check_value(input string name, input logic [15:0] exp,
			input logic [15:0] act);
		assert (exp == act) else begin
			$display("test failed");
			$display("ERR %s expected %h actual %h", name, exp, act);
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic report_failure(input string what);
		$display("test failed");
		$display("%s", what);
		$fatal(1, "run stopped");
	endtask

	// ============================================================
	// Expected colour rules
	// ============================================================

	// Each level step is worth 0x55
	function automatic channel_t level_to_channel(input color_level_t lvl);
		return channel_t'(lvl) * 8'h55;
	endfunction

	function automatic color_level_t brightest(input logic [5:0] rgb);
		color_level_t m;
		m = (rgb[5:4] > rgb[3:2]) ? rgb[5:4] : rgb[3:2];
		return (m > rgb[1:0]) ? m : rgb[1:0];
	endfunction

	// Channel 0 is red, 1 green, 2 blue
	function automatic channel_t mode_channel(input logic [5:0] rgb, input display_mode_t mode,
			input int ch);
		channel_t lum;
		lum = level_to_channel(brightest(rgb));
		case (mode)
			DISP_BW:    return lum;
			DISP_GREEN: return (ch == 1) ? lum : 8'h00;
			DISP_AMBER: return (ch == 0) ? lum : ((ch == 1) ? (lum >> 1) : 8'h00);
			default:    return level_to_channel(rgb[5-2*ch -: 2]);
		endcase
	endfunction

	// ============================================================
	// Reference model driven by TB inputs only
	// ============================================================

	always @(posedge CLK_VIDEO) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
			report_failure("timeout, the test sequence did not complete in time");
	end

	always @(posedge CLK_VIDEO) begin
		if (!rst_n) begin
			m_div = 3'd0;
			m_ce  = 1'b0;
			pix_q.delete();
			// Pipeline starts with two zero pixels in flight
			pix_q.push_back(11'd0);
			pix_q.push_back(11'd0);
			{e_r, e_g, e_b, e_hs, e_vs, e_de} = '0;
			{e_sl, e_hq, e_sd, e_arx, e_ary, e_ja, e_jd} = '0;
			rate_hold = 0;
			last_rate = pixel_rate_normal;
		end else begin
			// Pipeline moves on the enable seen before this edge
			if (m_ce) begin
				head = pix_q.pop_front();
				e_hs = head[8];
				e_vs = head[7];
				e_de = ~head[6];
				e_r  = head[6] ? 8'h00 :
					mode_channel(head[5:0], display_mode_t'(head[10:9]), 0);
				e_g  = head[6] ? 8'h00 :
					mode_channel(head[5:0], display_mode_t'(head[10:9]), 1);
				e_b  = head[6] ? 8'h00 :
					mode_channel(head[5:0], display_mode_t'(head[10:9]), 2);
				// Captured pixel enters expansion under the current mode
				head = pix_q[0];
				head[10:9] = display_mode;
				pix_q[0] = head;
				pix_q.push_back({2'b00, hsync, vsync, hblank | vblank,
					r_level, g_level, b_level});
			end
			// One clock in 8 at normal rate, one in 4 otherwise
			if (pixel_rate_normal)
				m_ce = (m_div == 3'd7);
			else
				m_ce = (m_div[1:0] == 2'b11);
			m_div = m_div + 3'd1;
			rate_hold = (pixel_rate_normal == last_rate) ? rate_hold + 1 : 0;
			last_rate = pixel_rate_normal;
			// Scaler menu decode
			e_sl = (scale == 3'd0) ? 2'd0 : scanline_t'(scale[1:0] - 2'd1);
			e_hq = (scale == HQ2X_SCALE);
			e_sd = (scale != 3'd0) || forced_scandoubler;
			e_arx = (aspect_mode == 2'd0) ? ASPECT_ORIG_X : aspect_t'(aspect_mode) - 12'd1;
			e_ary = (aspect_mode == 2'd0) ? ASPECT_ORIG_Y : 12'd0;
			// Joystick swap, paddle offset and masking
			stk  = axes_normal ? joystick_analog :
				{joystick_analog[7:0], joystick_analog[15:8]};
			e_ja = {paddle_x ? (paddle ^ 8'h80) : stk[15:8],
				paddle_y ? (paddle ^ 8'h80) : stk[7:0]};
			e_jd = joystick;
			if (stk[7:0] != 8'h00)
				e_jd[3:2] = 2'b00;
			if (stk[15:8] != 8'h00)
				e_jd[1:0] = 2'b00;
		end
	end

	// ============================================================
	// Checks on the falling edge where outputs are stable
	// ============================================================

	assert property (@(posedge CLK_VIDEO) disable iff (!rst_n) ce_pixel |=> !ce_pixel)
		else report_failure("ce_pixel stayed high for two clocks in a row");

	always @(negedge CLK_VIDEO) begin
		if (rst_n !== 1'b1) begin
			gap     = 0;
			seen_ce = 1'b0;
		end else begin
			check_value("ce_pixel", 16'(m_ce), 16'(ce_pixel));
			check_value("vga_r", 16'(e_r), 16'(vga_r));
			check_value("vga_g", 16'(e_g), 16'(vga_g));
			check_value("vga_b", 16'(e_b), 16'(vga_b));
			check_value("vga_hs", 16'(e_hs), 16'(vga_hs));
			check_value("vga_vs", 16'(e_vs), 16'(vga_vs));
			check_value("vga_de", 16'(e_de), 16'(vga_de));
			check_value("vga_sl", 16'(e_sl), 16'(vga_sl));
			check_value("hq2x", 16'(e_hq), 16'(hq2x));
			check_value("scandoubler", 16'(e_sd), 16'(scandoubler));
			check_value("video_arx", 16'(e_arx), 16'(video_arx));
			check_value("video_ary", 16'(e_ary), 16'(video_ary));
			check_value("joy_digital", 16'(e_jd), 16'(joy_digital));
			check_value("joy_analog", 16'(e_ja), 16'(joy_analog));
			// Pulse spacing once the rate has settled
			gap = gap + 1;
			if (ce_pixel) begin
				if (seen_ce && rate_hold >= 16)
					check_value("ce_pixel spacing", 16'(last_rate ? 8 : 4), 16'(gap));
				seen_ce = 1'b1;
				gap     = 0;
			end
		end
	end

	// ============================================================
	// Stimulus
	// ============================================================

	// Axes are often centred so the masking gets exercised
	task automatic drive_joystick();
		joystick = joy_digital_t'($urandom_range(0, 63));
		joystick_analog[15:8] = ($urandom_range(0, 1) == 1) ?
			axis_t'($urandom_range(0, 255)) : 8'h00;
		joystick_analog[7:0]  = ($urandom_range(0, 1) == 1) ?
			axis_t'($urandom_range(0, 255)) : 8'h00;
		paddle      = axis_t'($urandom_range(0, 255));
		axes_normal = 1'($urandom_range(0, 1));
		paddle_x    = ($urandom_range(0, 3) == 0);
		paddle_y    = ($urandom_range(0, 3) == 0);
	endtask

	task automatic run_cycles(input int n, input logic rate, input logic rand_blank,
			input logic rand_mode);
		repeat (n) begin
			@(posedge CLK_VIDEO);
			#2;
			pixel_rate_normal = rate;
			r_level = color_level_t'($urandom_range(0, 3));
			g_level = color_level_t'($urandom_range(0, 3));
			b_level = color_level_t'($urandom_range(0, 3));
			hsync   = 1'($urandom_range(0, 1));
			vsync   = 1'($urandom_range(0, 1));
			hblank  = rand_blank ? ($urandom_range(0, 5) == 0) : 1'b0;
			vblank  = rand_blank ? ($urandom_range(0, 5) == 0) : 1'b0;
			if (rand_mode)
				display_mode = display_mode_t'($urandom_range(0, 3));
			drive_joystick();
		end
	endtask

	initial begin
		void'($urandom(13213));
		rst_n = 1'b0;
		pixel_rate_normal = 1'b0;
		{r_level, g_level, b_level} = '0;
		{hsync, vsync, hblank, vblank} = '0;
		display_mode = DISP_COLOR;
		scale = '0;
		forced_scandoubler = 1'b0;
		aspect_mode = 2'd0;
		joystick = '0;
		joystick_analog = '0;
		paddle = '0;
		{axes_normal, paddle_x, paddle_y} = 3'b100;
		repeat (5) @(posedge CLK_VIDEO);
		#2;
		rst_n = 1'b1;

		// Colour mode at both pixel rates
		run_cycles(250, 1'b0, 1'b0, 1'b0);
		run_cycles(250, 1'b1, 1'b0, 1'b0);
		run_cycles(250, 1'b0, 1'b0, 1'b0);
		run_cycles(250, 1'b1, 1'b0, 1'b0);

		// Monochrome modes
		display_mode = DISP_BW;
		run_cycles(200, 1'b0, 1'b0, 1'b0);
		display_mode = DISP_GREEN;
		run_cycles(200, 1'b1, 1'b0, 1'b0);
		display_mode = DISP_AMBER;
		run_cycles(200, 1'b0, 1'b0, 1'b0);

		// Random blanking with a changing mode
		run_cycles(400, 1'b1, 1'b1, 1'b1);

		// Every scaler and aspect setting
		for (int s = 0; s < 8; s++) begin
			for (int f = 0; f < 2; f++) begin
				for (int a = 0; a < 4; a++) begin
					scale = scale_t'(s);
					forced_scandoubler = 1'(f);
					aspect_mode = 2'(a);
					run_cycles(2, 1'b0, 1'b1, 1'b1);
				end
			end
		end

		// Joystick keeps random values every clock
		run_cycles(500, 1'b0, 1'b1, 1'b1);

		$display("test passed");
		$finish;
	end

endmodule
